/* hdl/lsu_pkg.sv */
package lsu_pkg;

    // Register and data bus width, fixed by the RV32 access sizes
    localparam int XLEN = 32;

    // One strobe bit per byte lane
    localparam int STRB_WIDTH = XLEN / 8;

    // ------------------------------------------------------------
    // Load/store operations
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LH   = 4'd2,
        OP_LW   = 4'd3,
        OP_LBU  = 4'd4,
        OP_LHU  = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } lsu_op_e;

    // Access size of one request
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } lsu_size_e;

    // ------------------------------------------------------------
    // AXI4-Lite transaction FSM states
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_RD_ADDR = 3'd1,
        ST_RD_DATA = 3'd2,
        ST_WR_REQ  = 3'd3,
        ST_WR_RESP = 3'd4
    } axi_state_e;

endpackage

/* hdl/lsu_decode.sv */
`timescale 1ns/1ps

module lsu_decode #(
    parameter int ADDR_WIDTH = 32
) (
    input  lsu_pkg::lsu_op_e               i_op,
    input  logic [1:0]                     i_addr_lo,
    input  logic [lsu_pkg::XLEN-1:0]       i_wdata,
    output logic                           o_is_load,
    output logic                           o_is_store,
    output lsu_pkg::lsu_size_e             o_size,
    output logic                           o_signed,
    output logic [lsu_pkg::STRB_WIDTH-1:0] o_strb,
    output logic [lsu_pkg::XLEN-1:0]       o_wdata
);
    import lsu_pkg::*;

    // Lanes covered by the access before the offset shift
    logic [STRB_WIDTH-1:0] base_strb;

    // Byte offset needs at least two address bits
    if (ADDR_WIDTH < 2)
    begin : g_addr_width_check
        $error("lsu_decode: ADDR_WIDTH must be at least 2");
    end

    // ------------------------------------------------------------
    // Operation class, size and sign rule
    // ------------------------------------------------------------
    always_comb
    begin
        o_is_load  = 1'b0;
        o_is_store = 1'b0;
        o_size     = SIZE_WORD;
        o_signed   = 1'b0;
        case (i_op)
            OP_LB:  begin o_is_load = 1'b1; o_size = SIZE_BYTE; o_signed = 1'b1; end
            OP_LH:  begin o_is_load = 1'b1; o_size = SIZE_HALF; o_signed = 1'b1; end
            OP_LW:  begin o_is_load = 1'b1; o_size = SIZE_WORD; end
            OP_LBU: begin o_is_load = 1'b1; o_size = SIZE_BYTE; end
            OP_LHU: begin o_is_load = 1'b1; o_size = SIZE_HALF; end
            OP_SB:  begin o_is_store = 1'b1; o_size = SIZE_BYTE; end
            OP_SH:  begin o_is_store = 1'b1; o_size = SIZE_HALF; end
            OP_SW:  begin o_is_store = 1'b1; o_size = SIZE_WORD; end
            // OP_NONE and unused codes leave the request idle
            default: o_size = SIZE_WORD;
        endcase
    end

    // One, two or four lanes, moved to the byte offset
    always_comb
    begin
        case (o_size)
            SIZE_BYTE: base_strb = 4'b0001;
            SIZE_HALF: base_strb = 4'b0011;
            default:   base_strb = 4'b1111;
        endcase
        o_strb = o_is_store ? (base_strb << i_addr_lo) : '0;
    end

    // Replicate store data so every candidate lane carries it
    always_comb
    begin
        case (o_size)
            SIZE_BYTE: o_wdata = {4{i_wdata[7:0]}};
            SIZE_HALF: o_wdata = {2{i_wdata[15:0]}};
            default:   o_wdata = i_wdata;
        endcase
    end

endmodule

/* hdl/lsu_axi_master.sv */
`timescale 1ns/1ps

module lsu_axi_master #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                           M_AXI_ACLK,
    input  logic                           M_AXI_ARESETN,
    // Request from decode
    input  logic                           i_req,
    input  logic [ADDR_WIDTH-1:0]          i_addr,
    input  logic                           i_is_load,
    input  logic                           i_is_store,
    input  lsu_pkg::lsu_size_e             i_size,
    input  logic                           i_signed,
    input  logic [lsu_pkg::STRB_WIDTH-1:0] i_strb,
    input  logic [lsu_pkg::XLEN-1:0]       i_wdata,
    // Status and read beat to the result stage
    output logic                           o_busy,
    output logic [lsu_pkg::XLEN-1:0]       o_rd_beat,
    output logic                           o_rd_strobe,
    output logic                           o_wr_strobe,
    output logic                           o_resp_err,
    output logic [1:0]                     o_addr_lo,
    output lsu_pkg::lsu_size_e             o_size,
    output logic                           o_signed,
    // AXI4-Lite master port
    output logic [ADDR_WIDTH-1:0]          o_m_axi_awaddr,
    output logic                           o_m_axi_awvalid,
    input  logic                           i_m_axi_awready,
    output logic [lsu_pkg::XLEN-1:0]       o_m_axi_wdata,
    output logic [lsu_pkg::STRB_WIDTH-1:0] o_m_axi_wstrb,
    output logic                           o_m_axi_wvalid,
    input  logic                           i_m_axi_wready,
    input  logic [1:0]                     i_m_axi_bresp,
    input  logic                           i_m_axi_bvalid,
    output logic                           o_m_axi_bready,
    output logic [ADDR_WIDTH-1:0]          o_m_axi_araddr,
    output logic                           o_m_axi_arvalid,
    input  logic                           i_m_axi_arready,
    input  logic [lsu_pkg::XLEN-1:0]       i_m_axi_rdata,
    input  logic [1:0]                     i_m_axi_rresp,
    input  logic                           i_m_axi_rvalid,
    output logic                           o_m_axi_rready
);
    import lsu_pkg::*;

    axi_state_e            state_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [XLEN-1:0]       wdata_q;
    logic [STRB_WIDTH-1:0] wstrb_q;
    logic                  awvalid_q;
    logic                  wvalid_q;
    logic                  arvalid_q;
    logic                  rready_q;
    logic                  bready_q;
    logic                  accept;
    logic                  aw_xfer;
    logic                  w_xfer;
    logic                  b_xfer;
    logic                  ar_xfer;
    logic                  r_xfer;
    logic                  aw_pending;
    logic                  w_pending;

    // Request taken only when idle and it names a real access
    assign accept = i_req & ~o_busy & (i_is_load | i_is_store);

    // Channel handshakes
    assign aw_xfer = awvalid_q & i_m_axi_awready;
    assign w_xfer  = wvalid_q & i_m_axi_wready;
    assign b_xfer  = bready_q & i_m_axi_bvalid;
    assign ar_xfer = arvalid_q & i_m_axi_arready;
    assign r_xfer  = rready_q & i_m_axi_rvalid;

    // AW or W still waiting after this edge
    assign aw_pending = awvalid_q & ~i_m_axi_awready;
    assign w_pending  = wvalid_q & ~i_m_axi_wready;

    // ------------------------------------------------------------
    // Transaction FSM and channel valids/readies
    // ------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            state_q   <= ST_IDLE;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
            bready_q  <= 1'b0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (accept && i_is_load)
                    begin
                        arvalid_q <= 1'b1;
                        state_q   <= ST_RD_ADDR;
                    end
                    else if (accept)
                    begin
                        // Address and data offered together
                        awvalid_q <= 1'b1;
                        wvalid_q  <= 1'b1;
                        state_q   <= ST_WR_REQ;
                    end
                end
                ST_RD_ADDR:
                begin
                    if (ar_xfer)
                    begin
                        arvalid_q <= 1'b0;
                        rready_q  <= 1'b1;
                        state_q   <= ST_RD_DATA;
                    end
                end
                ST_RD_DATA:
                begin
                    if (r_xfer)
                    begin
                        rready_q <= 1'b0;
                        state_q  <= ST_IDLE;
                    end
                end
                ST_WR_REQ:
                begin
                    // Each valid drops on its own transfer
                    if (aw_xfer)
                        awvalid_q <= 1'b0;
                    if (w_xfer)
                        wvalid_q <= 1'b0;
                    if (!aw_pending && !w_pending)
                    begin
                        bready_q <= 1'b1;
                        state_q  <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP:
                begin
                    if (b_xfer)
                    begin
                        bready_q <= 1'b0;
                        state_q  <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Status toward the result stage
    // ------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            o_busy      <= 1'b0;
            o_rd_strobe <= 1'b0;
            o_wr_strobe <= 1'b0;
            o_resp_err  <= 1'b0;
        end
        else
        begin
            o_rd_strobe <= r_xfer;
            o_wr_strobe <= b_xfer;
            // SLVERR and DECERR both have bit 1 set
            if (r_xfer)
                o_resp_err <= i_m_axi_rresp[1];
            else if (b_xfer)
                o_resp_err <= i_m_axi_bresp[1];
            // Busy ends together with the done pulse
            if (accept)
                o_busy <= 1'b1;
            else if (o_rd_strobe || o_wr_strobe)
                o_busy <= 1'b0;
        end
    end

    // Payload captured at acceptance and on the R beat
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (accept)
        begin
            addr_q    <= i_addr;
            wdata_q   <= i_wdata;
            wstrb_q   <= i_strb;
            o_addr_lo <= i_addr[1:0];
            o_size    <= i_size;
            o_signed  <= i_signed;
        end
        if (r_xfer)
            o_rd_beat <= i_m_axi_rdata;
    end

    // Address goes out unchanged on both channels
    assign o_m_axi_awaddr  = addr_q;
    assign o_m_axi_araddr  = addr_q;
    assign o_m_axi_wdata   = wdata_q;
    assign o_m_axi_wstrb   = wstrb_q;
    assign o_m_axi_awvalid = awvalid_q;
    assign o_m_axi_wvalid  = wvalid_q;
    assign o_m_axi_arvalid = arvalid_q;
    assign o_m_axi_rready  = rready_q;
    assign o_m_axi_bready  = bready_q;

endmodule

/* hdl/lsu_load_align.sv */
`timescale 1ns/1ps

module lsu_load_align (
    input  logic                     M_AXI_ACLK,
    input  logic                     M_AXI_ARESETN,
    input  logic [lsu_pkg::XLEN-1:0] i_rd_beat,
    input  logic                     i_rd_strobe,
    input  logic                     i_wr_strobe,
    input  logic                     i_resp_err,
    input  logic [1:0]               i_addr_lo,
    input  lsu_pkg::lsu_size_e       i_size,
    input  logic                     i_signed,
    output logic                     o_done,
    output logic [lsu_pkg::XLEN-1:0] o_rdata,
    output logic                     o_err
);
    import lsu_pkg::*;

    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] extended;

    // Addressed lane moved down to bit 0
    assign shifted = i_rd_beat >> {i_addr_lo, 3'b000};

    // Mask to size, then sign or zero fill
    always_comb
    begin
        case (i_size)
            SIZE_BYTE: extended = {{(XLEN-8){i_signed & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: extended = {{(XLEN-16){i_signed & shifted[15]}}, shifted[15:0]};
            default:   extended = shifted;
        endcase
    end

    // Done, data and error leave together
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            o_done  <= 1'b0;
            o_rdata <= '0;
            o_err   <= 1'b0;
        end
        else
        begin
            o_done <= i_rd_strobe | i_wr_strobe;
            o_err  <= (i_rd_strobe | i_wr_strobe) & i_resp_err;
            if (i_rd_strobe)
                o_rdata <= extended;
            // stores report zero data
            else if (i_wr_strobe)
                o_rdata <= '0;
        end
    end

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                           M_AXI_ACLK,
    input  logic                           M_AXI_ARESETN,
    // Request side
    input  logic                           i_req,
    input  lsu_pkg::lsu_op_e               i_op,
    input  logic [ADDR_WIDTH-1:0]          i_addr,
    input  logic [lsu_pkg::XLEN-1:0]       i_wdata,
    output logic                           o_busy,
    output logic                           o_done,
    output logic [lsu_pkg::XLEN-1:0]       o_rdata,
    output logic                           o_err,
    // AXI4-Lite master port
    output logic [ADDR_WIDTH-1:0]          o_m_axi_awaddr,
    output logic                           o_m_axi_awvalid,
    input  logic                           i_m_axi_awready,
    output logic [lsu_pkg::XLEN-1:0]       o_m_axi_wdata,
    output logic [lsu_pkg::STRB_WIDTH-1:0] o_m_axi_wstrb,
    output logic                           o_m_axi_wvalid,
    input  logic                           i_m_axi_wready,
    input  logic [1:0]                     i_m_axi_bresp,
    input  logic                           i_m_axi_bvalid,
    output logic                           o_m_axi_bready,
    output logic [ADDR_WIDTH-1:0]          o_m_axi_araddr,
    output logic                           o_m_axi_arvalid,
    input  logic                           i_m_axi_arready,
    input  logic [lsu_pkg::XLEN-1:0]       i_m_axi_rdata,
    input  logic [1:0]                     i_m_axi_rresp,
    input  logic                           i_m_axi_rvalid,
    output logic                           o_m_axi_rready
);
    import lsu_pkg::*;

    // Decode results, live with the request
    logic                  is_load;
    logic                  is_store;
    lsu_size_e             acc_size;
    logic                  acc_signed;
    logic [STRB_WIDTH-1:0] acc_strb;
    logic [XLEN-1:0]       acc_wdata;
    // Execute results, held for the accepted request
    logic [XLEN-1:0]       rd_beat;
    logic                  rd_strobe;
    logic                  wr_strobe;
    logic                  resp_err;
    logic [1:0]            addr_lo;
    lsu_size_e             rsp_size;
    logic                  rsp_signed;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    lsu_decode #(.ADDR_WIDTH(ADDR_WIDTH)) u_decode (
        .i_op       (i_op),
        .i_addr_lo  (i_addr[1:0]),
        .i_wdata    (i_wdata),
        .o_is_load  (is_load),
        .o_is_store (is_store),
        .o_size     (acc_size),
        .o_signed   (acc_signed),
        .o_strb     (acc_strb),
        .o_wdata    (acc_wdata)
    );

    // ------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------
    lsu_axi_master #(.ADDR_WIDTH(ADDR_WIDTH)) u_axi_master (
        .M_AXI_ACLK      (M_AXI_ACLK),
        .M_AXI_ARESETN   (M_AXI_ARESETN),
        .i_req           (i_req),
        .i_addr          (i_addr),
        .i_is_load       (is_load),
        .i_is_store      (is_store),
        .i_size          (acc_size),
        .i_signed        (acc_signed),
        .i_strb          (acc_strb),
        .i_wdata         (acc_wdata),
        .o_busy          (o_busy),
        .o_rd_beat       (rd_beat),
        .o_rd_strobe     (rd_strobe),
        .o_wr_strobe     (wr_strobe),
        .o_resp_err      (resp_err),
        .o_addr_lo       (addr_lo),
        .o_size          (rsp_size),
        .o_signed        (rsp_signed),
        .o_m_axi_awaddr  (o_m_axi_awaddr),
        .o_m_axi_awvalid (o_m_axi_awvalid),
        .i_m_axi_awready (i_m_axi_awready),
        .o_m_axi_wdata   (o_m_axi_wdata),
        .o_m_axi_wstrb   (o_m_axi_wstrb),
        .o_m_axi_wvalid  (o_m_axi_wvalid),
        .i_m_axi_wready  (i_m_axi_wready),
        .i_m_axi_bresp   (i_m_axi_bresp),
        .i_m_axi_bvalid  (i_m_axi_bvalid),
        .o_m_axi_bready  (o_m_axi_bready),
        .o_m_axi_araddr  (o_m_axi_araddr),
        .o_m_axi_arvalid (o_m_axi_arvalid),
        .i_m_axi_arready (i_m_axi_arready),
        .i_m_axi_rdata   (i_m_axi_rdata),
        .i_m_axi_rresp   (i_m_axi_rresp),
        .i_m_axi_rvalid  (i_m_axi_rvalid),
        .o_m_axi_rready  (o_m_axi_rready)
    );

    // Result extraction and completion
    lsu_load_align u_load_align (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_rd_beat     (rd_beat),
        .i_rd_strobe   (rd_strobe),
        .i_wr_strobe   (wr_strobe),
        .i_resp_err    (resp_err),
        .i_addr_lo     (addr_lo),
        .i_size        (rsp_size),
        .i_signed      (rsp_signed),
        .o_done        (o_done),
        .o_rdata       (o_rdata),
        .o_err         (o_err)
    );

endmodule

/* verif/lsu_assert.sv */
`timescale 1ns/1ps

module lsu_assert (
    input logic                M_AXI_ACLK,
    input logic                M_AXI_ARESETN,
    input lsu_pkg::axi_state_e i_state,
    input logic                i_busy,
    input logic                i_rd_strobe,
    input logic                i_wr_strobe,
    input logic                i_awvalid,
    input logic                i_awready,
    input logic                i_wvalid,
    input logic                i_wready,
    input logic                i_arvalid,
    input logic                i_arready
);
    import lsu_pkg::*;

    // Failures seen by the testbench summary
    int   fail_count = 0;
    // Completion source, done follows it one cycle later
    logic fin;

    assign fin = i_rd_strobe | i_wr_strobe;

    // ------------------------------------------------------------
    // Valid held until its transfer
    // ------------------------------------------------------------
    a_aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_awvalid && !i_awready |=> i_awvalid)
    else
    begin
        fail_count++;
        $error("AW valid dropped before its transfer");
    end

    a_w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_wvalid && !i_wready |=> i_wvalid)
    else
    begin
        fail_count++;
        $error("W valid dropped before its transfer");
    end

    a_ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_arvalid && !i_arready |=> i_arvalid)
    else
    begin
        fail_count++;
        $error("AR valid dropped before its transfer");
    end

    // Idle FSM drives no valid
    a_idle_quiet: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        i_state == ST_IDLE |-> !(i_awvalid || i_wvalid || i_arvalid))
    else
    begin
        fail_count++;
        $error("Valid high while the FSM is idle");
    end

    // Completion lasts one cycle and ends busy
    a_fin_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        fin |=> !fin && !i_busy)
    else
    begin
        fail_count++;
        $error("Completion longer than one cycle or busy still high");
    end

endmodule

bind lsu_axi_master lsu_assert u_lsu_assert (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .i_state       (state_q),
    .i_busy        (o_busy),
    .i_rd_strobe   (o_rd_strobe),
    .i_wr_strobe   (o_wr_strobe),
    .i_awvalid     (o_m_axi_awvalid),
    .i_awready     (i_m_axi_awready),
    .i_wvalid      (o_m_axi_wvalid),
    .i_wready      (i_m_axi_wready),
    .i_arvalid     (o_m_axi_arvalid),
    .i_arready     (i_m_axi_arready)
);

/* verif/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int N_DIRECTED = 10;
    localparam int N_RANDOM   = 200;
    localparam int N_REQ      = N_DIRECTED + N_RANDOM;

    logic            M_AXI_ACLK;
    logic            M_AXI_ARESETN;
    logic            i_req;
    lsu_op_e         i_op;
    logic [31:0]     i_addr;
    logic [XLEN-1:0] i_wdata;
    logic            o_busy;
    logic            o_done;
    logic [XLEN-1:0] o_rdata;
    logic            o_err;
    logic [31:0]     o_m_axi_awaddr;
    logic            o_m_axi_awvalid;
    logic            i_m_axi_awready;
    logic [XLEN-1:0] o_m_axi_wdata;
    logic [3:0]      o_m_axi_wstrb;
    logic            o_m_axi_wvalid;
    logic            i_m_axi_wready;
    logic [1:0]      i_m_axi_bresp;
    logic            i_m_axi_bvalid;
    logic            o_m_axi_bready;
    logic [31:0]     o_m_axi_araddr;
    logic            o_m_axi_arvalid;
    logic            i_m_axi_arready;
    logic [XLEN-1:0] i_m_axi_rdata;
    logic [1:0]      i_m_axi_rresp;
    logic            i_m_axi_rvalid;
    logic            o_m_axi_rready;

    // Slave memory and the shadow copy of the reference model
    logic [31:0] mem [0:63];
    logic [31:0] model_mem [0:63];
    // Slave channel state
    int          aw_wait;
    int          w_wait;
    int          ar_wait;
    int          b_wait;
    int          r_wait;
    logic        aw_hit;
    logic        w_hit;
    logic        ar_hit;
    logic        r_hit;
    logic        b_hit;
    logic        aw_got;
    logic        w_got;
    logic        b_pend;
    logic        r_pend;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic [31:0] rd_addr;
    // Scoreboard
    int          errors;
    int          done_count;
    int          accepted;
    integer      seed;
    integer      delay_seed;

    lsu_top #(.ADDR_WIDTH(32)) UUT (.*);

    always #50 M_AXI_ACLK = ~M_AXI_ACLK;

    // Ready or response delay of 0 to 3 cycles
    function automatic int rand_delay();
        rand_delay = $unsigned($random(delay_seed)) % 4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("MISMATCH t=%0t %s expected=%h got=%h", $time, name, exp, got);
        end
    endtask

    // ------------------------------------------------------------
    // One request, its expected result and the model update
    // ------------------------------------------------------------
    task automatic do_access(input lsu_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] exp_data;
        logic        exp_err;
        logic        store;
        logic [3:0]  stray_op;
        word     = model_mem[addr[7:2]];
        b        = word[8*addr[1:0] +: 8];
        h        = word[16*addr[1] +: 16];
        exp_err  = addr[8];
        store    = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
        case (op)
            OP_LB:   exp_data = {{24{b[7]}}, b};
            OP_LH:   exp_data = {{16{h[15]}}, h};
            OP_LW:   exp_data = word;
            OP_LBU:  exp_data = {24'h0, b};
            OP_LHU:  exp_data = {16'h0, h};
            default: exp_data = 32'h0;
        endcase
        @(posedge M_AXI_ACLK);
        #1;
        i_req   = 1'b1;
        i_op    = op;
        i_addr  = addr;
        i_wdata = wdata;
        accepted++;
        // Strobe held into the busy cycle with a different request
        @(posedge M_AXI_ACLK);
        #1;
        stray_op = 4'(1 + $unsigned($random(seed)) % 8);
        i_op     = lsu_op_e'(stray_op);
        i_addr   = $unsigned($random(seed)) % 256;
        i_wdata  = $random(seed);
        @(posedge M_AXI_ACLK);
        #1;
        i_req = 1'b0;
        @(negedge M_AXI_ACLK);
        while (!o_done)
            @(negedge M_AXI_ACLK);
        check_value("o_err", 32'(o_err), 32'(exp_err));
        // Error loads carry no defined data
        if (store || !exp_err)
            check_value("o_rdata", o_rdata, exp_data);
        if (!exp_err)
        begin
            case (op)
                OP_SB:   model_mem[addr[7:2]][8*addr[1:0] +: 8] = wdata[7:0];
                OP_SH:   model_mem[addr[7:2]][16*addr[1] +: 16] = wdata[15:0];
                OP_SW:   model_mem[addr[7:2]] = wdata;
                default: ;
            endcase
        end
    endtask

    // ------------------------------------------------------------
    // AXI4-Lite memory slave, sampled at negedge, driven after posedge
    // ------------------------------------------------------------
    always
    begin
        @(negedge M_AXI_ACLK);
        aw_hit = o_m_axi_awvalid && i_m_axi_awready;
        w_hit  = o_m_axi_wvalid && i_m_axi_wready;
        ar_hit = o_m_axi_arvalid && i_m_axi_arready;
        r_hit  = i_m_axi_rvalid && o_m_axi_rready;
        b_hit  = i_m_axi_bvalid && o_m_axi_bready;
        if (aw_hit)
            wr_addr = o_m_axi_awaddr;
        if (w_hit)
        begin
            wr_data = o_m_axi_wdata;
            wr_strb = o_m_axi_wstrb;
        end
        if (ar_hit)
            rd_addr = o_m_axi_araddr;
        @(posedge M_AXI_ACLK);
        #1;
        // Ready drops for a random time after each transfer
        aw_wait = aw_hit ? rand_delay() : ((aw_wait > 0) ? aw_wait - 1 : 0);
        w_wait  = w_hit ? rand_delay() : ((w_wait > 0) ? w_wait - 1 : 0);
        ar_wait = ar_hit ? rand_delay() : ((ar_wait > 0) ? ar_wait - 1 : 0);
        i_m_axi_awready = (aw_wait == 0);
        i_m_axi_wready  = (w_wait == 0);
        i_m_axi_arready = (ar_wait == 0);
        // Write lands once address and data are both in
        aw_got = aw_got | aw_hit;
        w_got  = w_got | w_hit;
        if (aw_got && w_got)
        begin
            if (!wr_addr[8])
            begin
                for (int k = 0; k < 4; k++)
                    if (wr_strb[k])
                        mem[wr_addr[7:2]][8*k +: 8] = wr_data[8*k +: 8];
            end
            aw_got = 1'b0;
            w_got  = 1'b0;
            b_pend = 1'b1;
            b_wait = rand_delay();
        end
        if (b_hit)
            i_m_axi_bvalid = 1'b0;
        if (b_pend)
        begin
            if (b_wait == 0)
            begin
                i_m_axi_bvalid = 1'b1;
                i_m_axi_bresp  = wr_addr[8] ? 2'b10 : 2'b00;
                b_pend         = 1'b0;
            end
            else
                b_wait = b_wait - 1;
        end
        // Read beat after a random delay, SLVERR above the memory
        if (r_hit)
            i_m_axi_rvalid = 1'b0;
        if (ar_hit)
        begin
            r_pend = 1'b1;
            r_wait = rand_delay();
        end
        if (r_pend)
        begin
            if (r_wait == 0)
            begin
                i_m_axi_rvalid = 1'b1;
                i_m_axi_rdata  = mem[rd_addr[7:2]];
                i_m_axi_rresp  = rd_addr[8] ? 2'b10 : 2'b00;
                r_pend         = 1'b0;
            end
            else
                r_wait = r_wait - 1;
        end
    end

    // Every completion pulse
    always @(negedge M_AXI_ACLK)
    begin
        if (o_done)
            done_count++;
    end

    // Run limit scales with the request count
    initial
    begin
        repeat (N_REQ * 20 + 100) @(posedge M_AXI_ACLK);
        $display("Timeout: tests did not finish within %0d cycles", N_REQ * 20 + 100);
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial
    begin
        logic [3:0]  opc;
        logic [31:0] addr;
        lsu_op_e     op;
        seed            = 32'h4294;
        delay_seed      = 32'h4294;
        errors          = 0;
        done_count      = 0;
        accepted        = 0;
        M_AXI_ACLK      = 1'b0;
        M_AXI_ARESETN   = 1'b0;
        i_req           = 1'b0;
        i_op            = OP_NONE;
        i_addr          = 32'h0;
        i_wdata         = 32'h0;
        i_m_axi_awready = 1'b0;
        i_m_axi_wready  = 1'b0;
        i_m_axi_arready = 1'b0;
        i_m_axi_bvalid  = 1'b0;
        i_m_axi_bresp   = 2'b00;
        i_m_axi_rvalid  = 1'b0;
        i_m_axi_rdata   = 32'h0;
        i_m_axi_rresp   = 2'b00;
        {aw_wait, w_wait, ar_wait, b_wait, r_wait} = '0;
        {aw_got, w_got, b_pend, r_pend} = 4'b0000;
        // Fill pattern spread over every word index
        for (int i = 0; i < 64; i++)
        begin
            mem[i]       = (32'h9E37_79B9 * (i + 1)) ^ (i << 11);
            model_mem[i] = (32'h9E37_79B9 * (i + 1)) ^ (i << 11);
        end
        repeat (3) @(posedge M_AXI_ACLK);
        #1;
        M_AXI_ARESETN = 1'b1;
        // A strobe naming no access is dropped
        i_req = 1'b1;
        @(posedge M_AXI_ACLK);
        #1;
        i_req = 1'b0;
        repeat (4)
        begin
            @(negedge M_AXI_ACLK);
            assert (!(o_busy || o_done || o_m_axi_awvalid || o_m_axi_wvalid ||
                      o_m_axi_arvalid || o_m_axi_rready || o_m_axi_bready))
            else
            begin
                errors++;
                $display("Bus or status active with no request at t=%0t", $time);
            end
        end
        // Store then load, partial stores, sign rules, error region
        do_access(OP_SW, 32'h010, 32'h1234_5678);
        do_access(OP_LW, 32'h010, 32'h0);
        do_access(OP_SB, 32'h021, 32'h0000_00AB);
        do_access(OP_SH, 32'h022, 32'h0000_CDEF);
        do_access(OP_LW, 32'h020, 32'h0);
        do_access(OP_LB, 32'h021, 32'h0);
        do_access(OP_LHU, 32'h022, 32'h0);
        do_access(OP_SW, 32'h104, 32'hFFFF_FFFF);
        do_access(OP_LW, 32'h104, 32'h0);
        do_access(OP_LW, 32'h004, 32'h0);
        // Random mix, naturally aligned, about one in eight in the error region
        for (int n = 0; n < N_RANDOM; n++)
        begin
            opc  = 4'(1 + $unsigned($random(seed)) % 8);
            op   = lsu_op_e'(opc);
            addr = $unsigned($random(seed)) % 256;
            if ($unsigned($random(seed)) % 8 == 0)
                addr[8] = 1'b1;
            if (op == OP_LH || op == OP_LHU || op == OP_SH)
                addr[0] = 1'b0;
            if (op == OP_LW || op == OP_SW)
                addr[1:0] = 2'b00;
            do_access(op, addr, $random(seed));
        end
        repeat (10) @(negedge M_AXI_ACLK);
        check_value("done_count", done_count, accepted);
        $display("Errors: %0d check, %0d assertion; done pulses %0d for %0d requests",
                 errors, UUT.u_axi_master.u_lsu_assert.fail_count, done_count, accepted);
        if (errors == 0 && UUT.u_axi_master.u_lsu_assert.fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* lsu_top.f */
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_axi_master.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
verif/lsu_assert.sv
verif/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build the LSU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module lsu_tb -f lsu_top.f -o lsu_sim

out=$(./obj_dir/lsu_sim +verilator+error+limit+100)
echo "$out"

if echo "$out" | grep -q "Testbench passed"; then
    exit 0
else
    exit 1
fi
